// ==== bench/accel_tb.sv ====
`timescale 1ns/1ps
`include "accel_config.svh"

module accel_tb;

    localparam int NUM_BLOCKS  = 40;
    localparam int CLK_PERIOD  = 10;
    localparam int RESET_CYC   = 16;
    localparam int NUM_SAMPLES = NUM_BLOCKS * `ACCEL_BLOCK_LEN;
    localparam int WATCHDOG_NS =
        NUM_BLOCKS * (`ACCEL_BLOCK_LEN + `ACCEL_RESULT_WORDS) * 16 * CLK_PERIOD;

    logic                     clk;
    logic                     rst;
    logic                     in_valid;
    logic                     in_ready;
    logic [`ACCEL_DATA_W-1:0] in_data;
    logic                     out_valid;
    logic                     out_ready;
    logic [`ACCEL_DATA_W-1:0] out_data;
    logic                     out_last;

    // stimulus state
    logic [31:0] lfsr;
    logic [31:0] rnd;
    int          samples_sent;
    int          samples_acc;
    int          frames;
    int          err_data;
    int          err_last;
    int          err_proto;

    // reference model state
    int                       model_cnt;
    logic [`ACCEL_DATA_W-1:0] m_sum;
    logic [`ACCEL_DATA_W-1:0] m_min;
    logic [`ACCEL_DATA_W-1:0] m_max;
    logic [`ACCEL_DATA_W-1:0] m_xor;
    logic [`ACCEL_DATA_W-1:0] exp_data_q[$];
    logic                     exp_last_q[$];
    logic [`ACCEL_DATA_W-1:0] exp_d;
    logic                     exp_l;
    // block finished and its frame not yet fully taken
    logic                     blocked;
    // last beat seen stalled
    logic                     stall_prev;
    logic [`ACCEL_DATA_W-1:0] stall_data;
    logic                     stall_last;

    accel_top UUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_last  (out_last)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ========================================
    // random source
    // ========================================

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit
    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    // ========================================
    // monitor and model
    // ========================================

    // sampled on the rising edge before dut registers move
    always @(posedge clk) begin
        if (!rst) begin
            // input must stay closed until the frame is out
            if (blocked) begin
                assert (!in_ready) else begin
                    $display("in_ready high before the previous frame was accepted");
                    err_proto++;
                end
            end
            // stalled beat holds its value
            if (stall_prev) begin
                assert (out_valid) else begin
                    $display("out_valid dropped while the sink stalled");
                    err_proto++;
                end
                assert (out_data == stall_data) else begin
                    $display("ERR out_data exp=%h got=%h (stall)", stall_data, out_data);
                    err_data++;
                end
                assert (out_last == stall_last) else begin
                    $display("ERR out_last exp=%h got=%h (stall)", stall_last, out_last);
                    err_last++;
                end
            end
            stall_prev = out_valid && !out_ready;
            stall_data = out_data;
            stall_last = out_last;

            // fold each accepted sample into the model
            if (in_valid && in_ready) begin
                samples_acc++;
                if (model_cnt == 0) begin
                    m_sum = in_data;
                    m_min = in_data;
                    m_max = in_data;
                    m_xor = in_data;
                end else begin
                    m_sum = m_sum + in_data;
                    m_min = (in_data < m_min) ? in_data : m_min;
                    m_max = (in_data > m_max) ? in_data : m_max;
                    m_xor = m_xor ^ in_data;
                end
                model_cnt++;
                if (model_cnt == `ACCEL_BLOCK_LEN) begin
                    // frame order is sum min max xor
                    exp_data_q.push_back(m_sum);
                    exp_last_q.push_back(1'b0);
                    exp_data_q.push_back(m_min);
                    exp_last_q.push_back(1'b0);
                    exp_data_q.push_back(m_max);
                    exp_last_q.push_back(1'b0);
                    exp_data_q.push_back(m_xor);
                    exp_last_q.push_back(1'b1);
                    model_cnt = 0;
                    blocked   = 1'b1;
                end
            end

            // accepted beat against the queue head
            if (out_valid && out_ready) begin
                assert (exp_data_q.size() != 0) else begin
                    $display("beat accepted while no result was expected");
                    err_proto++;
                end
                if (exp_data_q.size() != 0) begin
                    exp_d = exp_data_q.pop_front();
                    exp_l = exp_last_q.pop_front();
                    assert (out_data == exp_d) else begin
                        $display("ERR out_data exp=%h got=%h", exp_d, out_data);
                        err_data++;
                    end
                    assert (out_last == exp_l) else begin
                        $display("ERR out_last exp=%h got=%h", exp_l, out_last);
                        err_last++;
                    end
                    if (exp_l) begin
                        blocked = 1'b0;
                    end
                end
                if (out_last) begin
                    frames++;
                end
            end
        end
    end

    // ========================================
    // stimulus
    // ========================================

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_data      = '0;
        out_ready    = 1'b0;
        lfsr         = 32'hfccb5759;
        samples_sent = 0;
        samples_acc  = 0;
        frames       = 0;
        err_data     = 0;
        err_last     = 0;
        err_proto    = 0;
        model_cnt    = 0;
        blocked      = 1'b0;
        stall_prev   = 1'b0;

        repeat (RESET_CYC) @(negedge clk);
        assert (!out_valid && !out_last) else begin
            $display("output stream active during reset");
            err_proto++;
        end
        assert (!in_ready) else begin
            $display("in_ready high during reset");
            err_proto++;
        end
        rst = 1'b0;
        @(negedge clk);
        assert (in_ready) else begin
            $display("in_ready did not rise after reset");
            err_proto++;
        end

        while (frames < NUM_BLOCKS) begin
            // offer taken on the last edge
            if (in_valid && samples_acc == samples_sent + 1) begin
                samples_sent++;
                in_valid = 1'b0;
            end
            // gap or new sample at even odds
            if (!in_valid && samples_sent < NUM_SAMPLES) begin
                draw_bits(1, rnd);
                if (rnd[0]) begin
                    draw_bits(`ACCEL_DATA_W, rnd);
                    in_data  = rnd[`ACCEL_DATA_W-1:0];
                    in_valid = 1'b1;
                end
            end
            // sink stalls one cycle in four
            draw_bits(2, rnd);
            out_ready = (rnd[1:0] != 2'b00);
            @(negedge clk);
        end

        // drain with no further samples
        in_valid  = 1'b0;
        out_ready = 1'b1;
        repeat (20) @(negedge clk);
        assert (exp_data_q.size() == 0) else begin
            $display("%0d expected beats never arrived", exp_data_q.size());
            err_proto++;
        end
        assert (frames == NUM_BLOCKS) else begin
            $display("frame count %0d differs from block count %0d", frames, NUM_BLOCKS);
            err_proto++;
        end

        $display("errors: out_data %0d, out_last %0d, protocol %0d",
                 err_data, err_last, err_proto);
        if (err_data + err_last + err_proto == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // ========================================
    // watchdog
    // ========================================

    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns with %0d of %0d frames received",
                 WATCHDOG_NS, frames, NUM_BLOCKS);
        $display("errors: out_data %0d, out_last %0d, protocol %0d",
                 err_data, err_last, err_proto);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== design/accel_config.svh ====
`ifndef ACCEL_CONFIG_SVH
`define ACCEL_CONFIG_SVH

// ========================================
// datapath sizing
// ========================================

// sample and result word width
`define ACCEL_DATA_W 16

// samples folded into one block
`define ACCEL_BLOCK_LEN 8

// ========================================
// output frame sizing
// ========================================

// result words per block, one frame
`define ACCEL_RESULT_WORDS 4
// bits to index one result word
`define ACCEL_IDX_W 2

`endif

// ==== design/accel_pkg.sv ====
`include "accel_config.svh"

package accel_pkg;

    // ========================================
    // compute side types
    // ========================================

    // one input sample, unsigned
    typedef logic [`ACCEL_DATA_W-1:0] sample_t;

    // one result word, same width as a sample
    typedef logic [`ACCEL_DATA_W-1:0] result_t;

    // result words, listed in output order
    typedef enum logic [`ACCEL_IDX_W-1:0] {
        SEL_SUM,
        SEL_MIN,
        SEL_MAX,
        SEL_XOR
    } result_sel_e;

endpackage

// ==== design/accel_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "accel_config.svh"

module accel_top (
    input  logic                     clk,
    input  logic                     rst,
    // sample input stream
    input  logic                     in_valid,
    output logic                     in_ready,
    input  logic [`ACCEL_DATA_W-1:0] in_data,
    // result output stream
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic [`ACCEL_DATA_W-1:0] out_data,
    output logic                     out_last
);

    // core to controller handoff
    result_if res ();

    block_core u_core (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_data  (in_data),
        .res      (res)
    );

    // out_* map onto the controller's dst_*
    stream_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .res       (res),
        .dst_ready (out_ready),
        .dst_valid (out_valid),
        .dst_data  (out_data),
        .dst_last  (out_last)
    );

endmodule

`default_nettype wire

// ==== design/agu.sv ====
`timescale 1ns/1ps
`default_nettype none

module agu #(
    parameter int W = 2
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         en,
    input  logic         start,
    input  logic [W-1:0] ini,
    input  logic [W-1:0] fin,
    output logic [W-1:0] data,
    output logic         last
);

    // a count is in progress
    logic running;

    // ========================================
    // counter
    // ========================================

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            data    <= '0;
        end else if (start) begin
            // load first value, count begins
            running <= 1'b1;
            data    <= ini;
        end else if (en && running) begin
            if (data == fin) begin
                // final step taken, stop here
                running <= 1'b0;
            end else begin
                data <= data + 1'b1;
            end
        end
    end

    // final step flag, only inside a count
    assign last = running && (data == fin);

    // owner must wait for the previous count to finish
    a_no_restart : assert property (
        @(posedge clk) disable iff (rst)
        start |-> !running
    ) else $error("agu start raised while a count is running");

endmodule

`default_nettype wire

// ==== design/block_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "accel_config.svh"

module block_core (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    output logic               in_ready,
    input  accel_pkg::sample_t in_data,
    result_if.core_side        res
);

    localparam int               CNT_W    = $clog2(`ACCEL_BLOCK_LEN);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`ACCEL_BLOCK_LEN - 1);

    // sample handshake
    logic             accept;
    // position of the next sample in the block
    logic [CNT_W-1:0] count;
    logic             first_smp;
    logic             final_smp;

    // accumulators, frozen while done is high
    accel_pkg::result_t sum_q;
    accel_pkg::result_t min_q;
    accel_pkg::result_t max_q;
    accel_pkg::result_t xor_q;

    assign accept    = in_valid && in_ready;
    assign first_smp = (count == '0);
    assign final_smp = (count == CNT_LAST);

    // ========================================
    // block control
    // ========================================

    always_ff @(posedge clk) begin
        if (rst) begin
            count    <= '0;
            in_ready <= 1'b0;
            res.done <= 1'b0;
        end else if (accept && final_smp) begin
            // block complete, hold results
            count    <= '0;
            in_ready <= 1'b0;
            res.done <= 1'b1;
        end else if (res.rel) begin
            // frame sent, open for the next block
            count    <= '0;
            in_ready <= 1'b1;
            res.done <= 1'b0;
        end else begin
            if (accept) begin
                count <= count + 1'b1;
            end
            // first cycle out of reset
            if (!res.done) begin
                in_ready <= 1'b1;
            end
        end
    end

    // ========================================
    // statistics
    // ========================================

    always_ff @(posedge clk) begin
        if (accept) begin
            if (first_smp) begin
                // first sample seeds every accumulator
                sum_q <= in_data;
                min_q <= in_data;
                max_q <= in_data;
                xor_q <= in_data;
            end else begin
                // sum wraps at the word width
                sum_q <= sum_q + in_data;
                if (in_data < min_q) begin
                    min_q <= in_data;
                end
                if (in_data > max_q) begin
                    max_q <= in_data;
                end
                xor_q <= xor_q ^ in_data;
            end
        end
    end

    // read port, plain mux on the held words
    always_comb begin
        case (res.rd_idx)
            accel_pkg::SEL_SUM: res.rd_data = sum_q;
            accel_pkg::SEL_MIN: res.rd_data = min_q;
            accel_pkg::SEL_MAX: res.rd_data = max_q;
            accel_pkg::SEL_XOR: res.rd_data = xor_q;
            default:            res.rd_data = sum_q;
        endcase
    end

    // controller only frees a block it was told about
    a_rel_when_done : assert property (
        @(posedge clk) disable iff (rst)
        res.rel |-> res.done
    ) else $error("release seen while done is low");

    // held results must not move under the reader
    a_no_take_when_done : assert property (
        @(posedge clk) disable iff (rst)
        res.done |-> !accept
    ) else $error("sample accepted while results are held");

endmodule

`default_nettype wire

// ==== design/result_if.sv ====
`timescale 1ns/1ps

interface result_if;

    // core side: results frozen and readable
    logic                   done;
    // ctrl side: word currently read
    accel_pkg::result_sel_e rd_idx;
    // core side: held word at rd_idx, no register
    accel_pkg::result_t     rd_data;
    // ctrl side: one-cycle release pulse, frees the core
    logic                   rel;

    modport core_side (
        output done,
        output rd_data,
        input  rd_idx,
        input  rel
    );

    modport ctrl_side (
        input  done,
        input  rd_data,
        output rd_idx,
        output rel
    );

endinterface

// ==== design/stream_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "accel_config.svh"

module stream_ctrl (
    input  logic               clk,
    input  logic               rst,
    result_if.ctrl_side        res,
    input  logic               dst_ready,
    output logic               dst_valid,
    output accel_pkg::result_t dst_data,
    output logic               dst_last
);

    // ========================================
    // done delay line
    // ========================================

    logic done_d1;
    logic done_d2;
    // block just finished, one cycle only
    logic done_rise;

    // always advances, no back-pressure here
    always_ff @(posedge clk) begin
        if (rst) begin
            done_d1 <= 1'b0;
            done_d2 <= 1'b0;
        end else begin
            done_d1 <= res.done;
            done_d2 <= done_d1;
        end
    end

    assign done_rise = done_d1 && !done_d2;

    // ========================================
    // frame start
    // ========================================

    // finished block not yet taken
    logic done_keep;
    // frame may begin this cycle
    logic stream_ok;
    // start pending, fires the agu
    logic start_keep;
    logic start;

    assign stream_ok = (done_rise || done_keep) && dst_ready;

    // remember the block until the sink is ready
    always_ff @(posedge clk) begin
        if (rst) begin
            done_keep <= 1'b0;
        end else if (stream_ok) begin
            done_keep <= 1'b0;
        end else if (done_rise) begin
            done_keep <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            start_keep <= 1'b0;
        end else if (dst_ready) begin
            start_keep <= stream_ok;
        end
    end

    assign start = dst_ready && start_keep;

    // ========================================
    // beat sequencing
    // ========================================

    stream_pkg::beat_idx_t beat_idx;
    // agu on its final step
    logic                  beat_last;
    // frame in progress
    logic                  active;

    // steps through the result words, stalls with the sink
    agu #(.W(`ACCEL_IDX_W)) u_agu (
        .clk   (clk),
        .rst   (rst),
        .en    (dst_ready),
        .start (start),
        .ini   (stream_pkg::beat_idx_t'(0)),
        .fin   (stream_pkg::beat_idx_t'(`ACCEL_RESULT_WORDS - 1)),
        .data  (beat_idx),
        .last  (beat_last)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
        end else if (start) begin
            active <= 1'b1;
        end else if (dst_ready && beat_last) begin
            active <= 1'b0;
        end
    end

    // beat position doubles as the result selector
    assign res.rd_idx = accel_pkg::result_sel_e'(beat_idx);

    // ========================================
    // output register and release
    // ========================================

    stream_pkg::beat_t beat_q;

    // everything holds while the sink stalls
    always_ff @(posedge clk) begin
        if (rst) begin
            dst_valid <= 1'b0;
            beat_q    <= '0;
        end else if (dst_ready) begin
            dst_valid   <= active;
            beat_q.data <= res.rd_data;
            beat_q.last <= active && beat_last;
        end
    end

    assign dst_data = beat_q.data;
    assign dst_last = beat_q.last;

    // pulse after the final beat leaves
    always_ff @(posedge clk) begin
        if (rst) begin
            res.rel <= 1'b0;
        end else begin
            res.rel <= dst_valid && dst_ready && dst_last;
        end
    end

    a_last_with_valid : assert property (
        @(posedge clk) disable iff (rst)
        dst_last |-> dst_valid
    ) else $error("dst_last high without dst_valid");

    // stalled beat stays put until taken
    a_hold_on_stall : assert property (
        @(posedge clk) disable iff (rst)
        (dst_valid && !dst_ready) |=> (dst_valid && $stable(dst_data) && $stable(dst_last))
    ) else $error("output beat changed while stalled");

endmodule

`default_nettype wire

// ==== design/stream_pkg.sv ====
`include "accel_config.svh"

package stream_pkg;

    // ========================================
    // output stream types
    // ========================================

    // beat position inside a frame
    typedef logic [`ACCEL_IDX_W-1:0] beat_idx_t;

    // one registered output beat
    typedef struct packed {
        accel_pkg::result_t data;
        logic               last;
    } beat_t;

endpackage

// ==== list.f ====
+incdir+design
design/accel_pkg.sv
design/stream_pkg.sv
design/result_if.sv
design/agu.sv
design/block_core.sv
design/stream_ctrl.sv
design/accel_top.sv
bench/accel_tb.sv
